// File: rtl/memPkg.sv
package memPkg;

    // one RAM data byte
    typedef logic [7:0] memByte;

    // load or store value, also the fetched instruction
    typedef logic [31:0] dataWord;

    // bytes per access: 1, 2 or 4
    typedef logic [2:0] accLen;

    localparam accLen lenByte = 3'd1;
    localparam accLen lenHalf = 3'd2;
    localparam accLen lenWord = 3'd4;

    // memRw encoding
    localparam logic memRead  = 1'b0;
    localparam logic memWrite = 1'b1;

endpackage

// File: rtl/instPkg.sv
package instPkg;

    // major opcodes
    localparam logic [6:0] opcLoad  = 7'b0000011;
    localparam logic [6:0] opcStore = 7'b0100011;
    localparam logic [6:0] opcOpImm = 7'b0010011;

    // funct3 for loads and stores
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;

    // funct3 for op-imm
    localparam logic [2:0] f3Addi = 3'b000;

    typedef enum logic [1:0] {
        opNop,
        opLoad,
        opStore,
        opAddi
    } opKind;

    // same word seen as I-type or S-type
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iView;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sView;
    } instWord;

endpackage

// File: rtl/memCtrl.sv
`timescale 1ns/1ps

module memCtrl #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  memPkg::memByte       memDin,
    output logic                 memRw,
    output logic [AddrWidth-1:0] memAddr,
    output memPkg::memByte       memDout,
    input  logic                 instReq,
    input  logic [AddrWidth-1:0] instAddr,
    output logic                 instDone,
    output memPkg::dataWord      instData,
    input  logic                 dataReq,
    input  logic                 dataStore,
    input  memPkg::accLen        dataLen,
    input  logic [AddrWidth-1:0] dataAddr,
    input  memPkg::dataWord      dataWdata,
    output logic                 dataDone,
    output memPkg::dataWord      dataRdata
);
    import memPkg::*;

    logic [2:0] stage;
    logic [2:0] prevStage;
    logic [2:0] lastStage;
    logic [2:0] offset;
    logic       ownerData;
    logic       useData;
    logic       busy;
    logic       active;
    logic       finish;
    dataWord    hold;
    dataWord    assembled;

    assign active    = rdy && !ioBufferFull;
    assign prevStage = stage - 3'd1;

    // owner picked at stage zero only, data side first
    always_comb begin
        if (stage == 3'd0) begin
            useData = dataReq;
            busy    = dataReq || instReq;
        end else begin
            useData = ownerData;
            busy    = ownerData ? dataReq : instReq;
        end
    end

    // loads and fetches need one extra stage for the read latency
    always_comb begin
        if (!useData) begin
            lastStage = 3'd4;
        end else if (dataStore) begin
            lastStage = dataLen - 3'd1;
        end else begin
            lastStage = dataLen;
        end
    end

    assign finish   = active && busy && (stage == lastStage);
    assign instDone = finish && !useData;
    assign dataDone = finish && useData;

    // paused: keep the previous address so memDin still carries the byte owed
    assign offset  = (active || stage == 3'd0) ? stage : prevStage;
    assign memAddr = (useData ? dataAddr : instAddr) + AddrWidth'(offset);
    assign memRw   = (active && busy && useData && dataStore) ? memWrite : memRead;
    assign memDout = dataWdata[{stage[1:0], 3'b000} +: 8];

    // incoming byte lands in slot stage-1
    always_comb begin
        assembled = hold;
        assembled[{prevStage[1:0], 3'b000} +: 8] = memDin;
    end

    assign instData  = assembled;
    assign dataRdata = assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage     <= 3'd0;
            ownerData <= 1'b0;
        end else if (active) begin
            if (!busy || finish) begin
                stage <= 3'd0;
            end else begin
                stage <= stage + 3'd1;
            end
            if (stage == 3'd0) begin
                ownerData <= dataReq;
            end
        end
    end

    // little-endian assembly
    always_ff @(posedge clk) begin
        if (active) begin
            if (stage == 3'd0) begin
                hold <= '0;
            end else begin
                hold <= assembled;
            end
        end
    end

endmodule

// File: rtl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
    parameter int                   AddrWidth = 17,
    parameter logic [AddrWidth-1:0] StartPc   = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 instReq,
    output logic [AddrWidth-1:0] instAddr,
    input  logic                 instDone,
    input  memPkg::dataWord      instData,
    output logic                 instValid,
    output instPkg::instWord     inst,
    input  logic                 instRetire
);
    logic [AddrWidth-1:0] pc;

    // ask for a word whenever none is held
    assign instReq  = !instValid;
    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= StartPc;
            instValid <= 1'b0;
        end else if (instRetire) begin
            pc        <= pc + AddrWidth'(4);
            instValid <= 1'b0;
        end else if (instDone) begin
            instValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (instDone) begin
            inst <= instData;
        end
    end

endmodule

// File: rtl/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
    input  instPkg::instWord inst,
    output instPkg::opKind   kind,
    output logic [4:0]       rd,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output memPkg::dataWord  imm,
    output memPkg::accLen    len,
    output logic             signExt
);
    import memPkg::*;
    import instPkg::*;

    dataWord iImm;
    dataWord sImm;

    assign iImm = {{20{inst.iView.imm[11]}}, inst.iView.imm};
    assign sImm = {{20{inst.sView.immHi[6]}}, inst.sView.immHi, inst.sView.immLo};

    // register fields sit at the same bits in both views
    assign rd  = inst.iView.rd;
    assign rs1 = inst.iView.rs1;
    assign rs2 = inst.sView.rs2;

    always_comb begin
        kind    = opNop;
        imm     = iImm;
        len     = lenWord;
        signExt = 1'b0;
        case (inst.iView.opcode)
            opcLoad: begin
                kind = opLoad;
                case (inst.iView.funct3)
                    f3Byte: begin
                        len     = lenByte;
                        signExt = 1'b1;
                    end
                    f3Half: begin
                        len     = lenHalf;
                        signExt = 1'b1;
                    end
                    f3Word:  len = lenWord;
                    f3ByteU: len = lenByte;
                    f3HalfU: len = lenHalf;
                    default: kind = opNop;
                endcase
            end
            opcStore: begin
                kind = opStore;
                imm  = sImm;
                case (inst.sView.funct3)
                    f3Byte:  len = lenByte;
                    f3Half:  len = lenHalf;
                    f3Word:  len = lenWord;
                    default: kind = opNop;
                endcase
            end
            opcOpImm: begin
                if (inst.iView.funct3 == f3Addi) begin
                    kind = opAddi;
                end
            end
            default: kind = opNop;
        endcase
    end

endmodule

// File: rtl/executeUnit.sv
`timescale 1ns/1ps

module executeUnit #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instValid,
    input  instPkg::opKind       kind,
    input  logic [4:0]           rd,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  memPkg::dataWord      imm,
    input  memPkg::accLen        len,
    input  logic                 signExt,
    output logic [4:0]           rs1Addr,
    output logic [4:0]           rs2Addr,
    input  memPkg::dataWord      rs1Val,
    input  memPkg::dataWord      rs2Val,
    output logic                 dataReq,
    output logic                 dataStore,
    output memPkg::accLen        dataLen,
    output logic [AddrWidth-1:0] dataAddr,
    output memPkg::dataWord      dataWdata,
    input  logic                 dataDone,
    input  memPkg::dataWord      dataRdata,
    output logic                 instRetire,
    output logic                 resultEn,
    output logic [4:0]           resultRd,
    output memPkg::dataWord      resultVal,
    output logic                 resultLoad,
    output memPkg::accLen        resultLen,
    output logic                 resultSign
);
    import memPkg::*;
    import instPkg::*;

    localparam logic [1:0] stIdle   = 2'd0;
    localparam logic [1:0] stAccess = 2'd1;
    localparam logic [1:0] stRetire = 2'd2;

    logic [1:0] state;
    logic       isMem;
    dataWord    loadData;

    assign rs1Addr = rs1;
    assign rs2Addr = rs2;
    assign isMem   = (kind == opLoad) || (kind == opStore);

    assign dataReq   = (state == stAccess);
    assign dataStore = (kind == opStore);
    assign dataLen   = len;
    assign dataAddr  = rs1Val[AddrWidth-1:0] + imm[AddrWidth-1:0];
    assign dataWdata = rs2Val;

    // addi and nop finish straight from idle
    always_comb begin
        instRetire = 1'b0;
        resultEn   = 1'b0;
        if (state == stIdle && instValid && !isMem) begin
            instRetire = 1'b1;
            resultEn   = (kind == opAddi);
        end else if (state == stRetire) begin
            instRetire = 1'b1;
            resultEn   = (kind == opLoad);
        end
    end

    assign resultRd   = rd;
    assign resultVal  = (kind == opLoad) ? loadData : rs1Val + imm;
    assign resultLoad = (kind == opLoad);
    assign resultLen  = len;
    assign resultSign = signExt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (instValid && isMem) begin
                        state <= stAccess;
                    end
                end
                stAccess: begin
                    if (dataDone) begin
                        state <= stRetire;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dataDone) begin
            loadData <= dataRdata;
        end
    end

endmodule

// File: rtl/resultUnit.sv
`timescale 1ns/1ps

module resultUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1Addr,
    input  logic [4:0]      rs2Addr,
    output memPkg::dataWord rs1Val,
    output memPkg::dataWord rs2Val,
    input  logic            resultEn,
    input  logic [4:0]      resultRd,
    input  memPkg::dataWord resultVal,
    input  logic            resultLoad,
    input  memPkg::accLen   resultLen,
    input  logic            resultSign,
    output logic            wbEn,
    output logic [4:0]      wbRd,
    output memPkg::dataWord wbData
);
    import memPkg::*;

    dataWord regs [32];
    logic    byteFill;
    logic    halfFill;

    // x0 reads as zero
    assign rs1Val = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Val = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    assign byteFill = resultSign && resultVal[7];
    assign halfFill = resultSign && resultVal[15];

    // loads narrower than a word get extended here
    always_comb begin
        wbData = resultVal;
        if (resultLoad) begin
            if (resultLen == lenByte) begin
                wbData = {{24{byteFill}}, resultVal[7:0]};
            end else if (resultLen == lenHalf) begin
                wbData = {{16{halfFill}}, resultVal[15:0]};
            end
        end
    end

    assign wbEn = resultEn && (resultRd != 5'd0);
    assign wbRd = resultRd;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn) begin
            regs[resultRd] <= wbData;
        end
    end

endmodule

// File: rtl/loadStoreCore.sv
`timescale 1ns/1ps

module loadStoreCore #(
    parameter int                   AddrWidth = 17,
    parameter logic [AddrWidth-1:0] StartPc   = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  memPkg::memByte       memDin,
    output logic                 memRw,
    output logic [AddrWidth-1:0] memAddr,
    output memPkg::memByte       memDout,
    output logic                 wbEn,
    output logic [4:0]           wbRd,
    output memPkg::dataWord      wbData
);
    import memPkg::*;
    import instPkg::*;

    // fetch side
    logic                 instReq;
    logic [AddrWidth-1:0] instAddr;
    logic                 instDone;
    dataWord              instData;
    logic                 instValid;
    instWord              inst;
    logic                 instRetire;

    // decoded fields
    opKind      kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    dataWord    imm;
    accLen      len;
    logic       signExt;

    // data side and register file
    logic                 dataReq;
    logic                 dataStore;
    accLen                dataLen;
    logic [AddrWidth-1:0] dataAddr;
    dataWord              dataWdata;
    logic                 dataDone;
    dataWord              dataRdata;
    logic [4:0]           rs1Addr;
    logic [4:0]           rs2Addr;
    dataWord              rs1Val;
    dataWord              rs2Val;
    logic                 resultEn;
    logic [4:0]           resultRd;
    dataWord              resultVal;
    logic                 resultLoad;
    accLen                resultLen;
    logic                 resultSign;

    memCtrl #(
        .AddrWidth(AddrWidth)
    ) memCtrl0 (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .ioBufferFull(ioBufferFull),
        .memDin(memDin),
        .memRw(memRw),
        .memAddr(memAddr),
        .memDout(memDout),
        .instReq(instReq),
        .instAddr(instAddr),
        .instDone(instDone),
        .instData(instData),
        .dataReq(dataReq),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata)
    );

    fetchUnit #(
        .AddrWidth(AddrWidth),
        .StartPc(StartPc)
    ) fetchUnit0 (
        .clk(clk),
        .rst(rst),
        .instReq(instReq),
        .instAddr(instAddr),
        .instDone(instDone),
        .instData(instData),
        .instValid(instValid),
        .inst(inst),
        .instRetire(instRetire)
    );

    decodeUnit decodeUnit0 (
        .inst(inst),
        .kind(kind),
        .rd(rd),
        .rs1(rs1),
        .rs2(rs2),
        .imm(imm),
        .len(len),
        .signExt(signExt)
    );

    executeUnit #(
        .AddrWidth(AddrWidth)
    ) executeUnit0 (
        .clk(clk),
        .rst(rst),
        .instValid(instValid),
        .kind(kind),
        .rd(rd),
        .rs1(rs1),
        .rs2(rs2),
        .imm(imm),
        .len(len),
        .signExt(signExt),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .dataReq(dataReq),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata),
        .instRetire(instRetire),
        .resultEn(resultEn),
        .resultRd(resultRd),
        .resultVal(resultVal),
        .resultLoad(resultLoad),
        .resultLen(resultLen),
        .resultSign(resultSign)
    );

    resultUnit resultUnit0 (
        .clk(clk),
        .rst(rst),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .resultEn(resultEn),
        .resultRd(resultRd),
        .resultVal(resultVal),
        .resultLoad(resultLoad),
        .resultLen(resultLen),
        .resultSign(resultSign),
        .wbEn(wbEn),
        .wbRd(wbRd),
        .wbData(wbData)
    );

endmodule

// File: dv/ramModel.sv
`timescale 1ns/1ps

module ramModel #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rw,
    input  logic [AddrWidth-1:0] addr,
    input  memPkg::memByte       wdata,
    output memPkg::memByte       rdata
);
    import memPkg::*;

    localparam int Depth = 1 << AddrWidth;

    memByte mem [Depth];

    // fill pattern mixes every address bit
    initial begin
        rdata = 8'h00;
        for (int i = 0; i < Depth; i++) begin
            mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16) ^ 32'h5a);
        end
    end

    // one cycle of read latency, read returns the old byte
    always @(posedge clk) begin
        rdata <= mem[addr];
        if (rw == memWrite) begin
            mem[addr] = wdata;
        end
    end

    // little-endian word into four bytes
    task automatic loadWord(input logic [AddrWidth-1:0] a, input dataWord w);
        for (int k = 0; k < 4; k++) begin
            mem[a + AddrWidth'(k)] = w[8*k +: 8];
        end
    endtask

    function automatic memByte peek(input logic [AddrWidth-1:0] a);
        return mem[a];
    endfunction

endmodule

// File: dv/loadStoreCoreTb.sv
`timescale 1ns/1ps

module loadStoreCoreTb;
    import memPkg::*;

    localparam int AddrWidth = 17;
    localparam int AddrMask  = (1 << AddrWidth) - 1;
    localparam int MaxWb     = 256;
    localparam int MaxWr     = 512;
    localparam int WaitLimit = 2000;
    localparam int PauseLen  = 1024;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic                 rdy = 1'b1;
    logic                 ioBufferFull = 1'b0;
    memByte               memDin;
    logic                 memRw;
    logic [AddrWidth-1:0] memAddr;
    memByte               memDout;
    logic                 wbEn;
    logic [4:0]           wbRd;
    dataWord              wbData;

    // expected write-backs and write cycles, in program order
    logic [4:0]           expRd [MaxWb];
    dataWord              expWb [MaxWb];
    string                wbName [MaxWb];
    logic [AddrWidth-1:0] expAddr [MaxWr];
    memByte               expByte [MaxWr];
    string                wrName [MaxWr];
    int                   wbTotal = 0;
    int                   wrTotal = 0;

    // reference model state
    dataWord              regModel [32];
    memByte               memModel [int];
    int                   pc = 0;
    int                   seed = 32'hc5c684e6;
    logic [1:0]           pausePat [PauseLen];
    int                   pauseIdx = 0;
    logic                 pauseOn = 1'b0;

    int                   wbIdx = 0;
    int                   wrIdx = 0;
    logic                 resetSeen = 1'b0;
    int                   valueErrors = 0;
    int                   otherErrors = 0;
    int                   timeoutErrors = 0;

    always #50 clk = ~clk;

    loadStoreCore #(
        .AddrWidth(AddrWidth),
        .StartPc('0)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .ioBufferFull(ioBufferFull),
        .memDin(memDin),
        .memRw(memRw),
        .memAddr(memAddr),
        .memDout(memDout),
        .wbEn(wbEn),
        .wbRd(wbRd),
        .wbData(wbData)
    );

    ramModel #(
        .AddrWidth(AddrWidth)
    ) ram0 (
        .clk(clk),
        .rw(memRw),
        .addr(memAddr),
        .wdata(memDout),
        .rdata(memDin)
    );

    // bit 0 stalls through rdy, bit 1 raises ioBufferFull
    always @(negedge clk) begin
        if (pauseOn) begin
            rdy = !pausePat[pauseIdx][0];
            ioBufferFull = pausePat[pauseIdx][1];
            pauseIdx = (pauseIdx + 1) % PauseLen;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wbIdx <= 0;
            wrIdx <= 0;
        end else begin
            if (wbEn) begin
                wbIdx <= wbIdx + 1;
            end
            if (memRw == memWrite) begin
                wrIdx <= wrIdx + 1;
            end
        end
        resetSeen <= resetSeen || rst;
    end

    assert property (@(posedge clk) (rst && resetSeen) |-> (memRw == memRead && !wbEn))
    else begin
        otherErrors++;
        $display("memory port wrote or write-back fired during reset");
    end

    assert property (@(posedge clk) disable iff (rst) (wbIdx == 0) |-> (memRw == memRead))
    else begin
        otherErrors++;
        $display("memory written before the first write-back");
    end

    assert property (@(posedge clk) disable iff (rst) wbEn |-> (wbRd != 5'd0))
    else begin
        otherErrors++;
        $display("write-back shown for register 0");
    end

    assert property (@(posedge clk) disable iff (rst) wbEn |-> (wbIdx < wbTotal))
    else begin
        otherErrors++;
        $display("write-back to x%0d that the program does not make", $sampled(wbRd));
    end

    assert property (@(posedge clk) disable iff (rst)
        (wbEn && wbIdx < wbTotal) |-> (wbRd == expRd[wbIdx]))
    else begin
        valueErrors++;
        $display("mismatch %s wbRd expected %0d actual %0d",
            wbName[$sampled(wbIdx)], expRd[$sampled(wbIdx)], $sampled(wbRd));
    end

    assert property (@(posedge clk) disable iff (rst)
        (wbEn && wbIdx < wbTotal) |-> (wbData == expWb[wbIdx]))
    else begin
        valueErrors++;
        $display("mismatch %s wbData expected %08h actual %08h",
            wbName[$sampled(wbIdx)], expWb[$sampled(wbIdx)], $sampled(wbData));
    end

    assert property (@(posedge clk) disable iff (rst) ioBufferFull |-> (memRw == memRead))
    else begin
        otherErrors++;
        $display("memory written while ioBufferFull was high");
    end

    assert property (@(posedge clk) disable iff (rst) (memRw == memWrite) |-> (wrIdx < wrTotal))
    else begin
        otherErrors++;
        $display("unexpected memory write at address %05h", $sampled(memAddr));
    end

    assert property (@(posedge clk) disable iff (rst)
        (memRw == memWrite && wrIdx < wrTotal) |-> (memAddr == expAddr[wrIdx]))
    else begin
        valueErrors++;
        $display("mismatch %s memAddr expected %05h actual %05h",
            wrName[$sampled(wrIdx)], expAddr[$sampled(wrIdx)], $sampled(memAddr));
    end

    assert property (@(posedge clk) disable iff (rst)
        (memRw == memWrite && wrIdx < wrTotal) |-> (memDout == expByte[wrIdx]))
    else begin
        valueErrors++;
        $display("mismatch %s memDout expected %02h actual %02h",
            wrName[$sampled(wrIdx)], expByte[$sampled(wrIdx)], $sampled(memDout));
    end

    function automatic dataWord sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic memByte modelByte(input int a);
        if (memModel.exists(a)) begin
            return memModel[a];
        end
        return ram0.peek(AddrWidth'(a));
    endfunction

    task automatic placeWord(input dataWord w);
        ram0.loadWord(AddrWidth'(pc), w);
        pc += 4;
    endtask

    task automatic writeBack(input logic [4:0] rd, input dataWord v, input string op);
        if (rd != 5'd0) begin
            regModel[rd] = v;
            expRd[wbTotal] = rd;
            expWb[wbTotal] = v;
            wbName[wbTotal] = $sformatf("%s@%0h", op, pc - 4);
            wbTotal++;
        end
    endtask

    task automatic addiInst(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        placeWord({imm, rs1, 3'b000, rd, 7'b0010011});
        writeBack(rd, regModel[rs1] + sext12(imm), "addi");
    endtask

    task automatic loadInst(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
        int      a;
        int      n;
        dataWord v;
        string   op;
        placeWord({imm, rs1, f3, rd, 7'b0000011});
        a = int'(regModel[rs1] + sext12(imm)) & AddrMask;
        n = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[8*k +: 8] = modelByte((a + k) & AddrMask);
        end
        case (f3)
            3'b000: begin
                v = {{24{v[7]}}, v[7:0]};
                op = "lb";
            end
            3'b001: begin
                v = {{16{v[15]}}, v[15:0]};
                op = "lh";
            end
            3'b100: op = "lbu";
            3'b101: op = "lhu";
            default: op = "lw";
        endcase
        writeBack(rd, v, op);
    endtask

    task automatic storeInst(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [11:0] imm);
        int    a;
        int    n;
        int    wa;
        string op;
        placeWord({imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011});
        a = int'(regModel[rs1] + sext12(imm)) & AddrMask;
        n = (f3 == 3'b000) ? 1 : (f3 == 3'b001) ? 2 : 4;
        op = (n == 1) ? "sb" : (n == 2) ? "sh" : "sw";
        for (int k = 0; k < n; k++) begin
            wa = (a + k) & AddrMask;
            expAddr[wrTotal] = AddrWidth'(wa);
            expByte[wrTotal] = regModel[rs2][8*k +: 8];
            wrName[wrTotal] = $sformatf("%s@%0h byte %0d", op, pc - 4, k);
            memModel[wa] = regModel[rs2][8*k +: 8];
            wrTotal++;
        end
    endtask

    task automatic buildProgram();
        int         r;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [2:0] lf3;
        logic [2:0] sf3;
        // data base at 0xfe0, well above the code
        addiInst(5'd1, 5'd0, 12'd2032);
        addiInst(5'd1, 5'd1, 12'd2032);
        // fill bytes, some of them negative
        loadInst(3'b000, 5'd2, 5'd1, 12'd3);
        loadInst(3'b001, 5'd3, 5'd1, 12'd6);
        loadInst(3'b100, 5'd4, 5'd1, 12'd3);
        loadInst(3'b101, 5'd5, 5'd1, 12'd6);
        loadInst(3'b010, 5'd6, 5'd1, 12'd8);
        // -128 and -1234 round trip
        addiInst(5'd7, 5'd0, 12'hf80);
        addiInst(5'd8, 5'd0, 12'hb2e);
        storeInst(3'b000, 5'd1, 5'd7, 12'd16);
        storeInst(3'b001, 5'd1, 5'd8, 12'd18);
        storeInst(3'b010, 5'd1, 5'd8, 12'd20);
        loadInst(3'b000, 5'd9, 5'd1, 12'd16);
        loadInst(3'b100, 5'd10, 5'd1, 12'd16);
        loadInst(3'b001, 5'd11, 5'd1, 12'd18);
        loadInst(3'b101, 5'd12, 5'd1, 12'd18);
        loadInst(3'b010, 5'd13, 5'd1, 12'd20);
        addiInst(5'd0, 5'd8, 12'd5);
        // unknown opcode, then a store with funct3 011
        placeWord(32'h1234_5073);
        placeWord({7'd0, 5'd8, 5'd1, 3'b011, 5'd0, 7'b0100011});
        addiInst(5'd14, 5'd0, 12'd77);
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            rd = 5'(2 + (r[7:4] % 14));
            rs = {1'b0, r[11:8]};
            lf3 = r[22:20];
            if (lf3 == 3'b011 || lf3[2:1] == 2'b11) begin
                lf3 = 3'b010;
            end
            sf3 = (r[21:20] == 2'b11) ? 3'b010 : {1'b0, r[21:20]};
            case (r[2:0])
                3'd3, 3'd4: loadInst(lf3, rd, 5'd1, {4'd0, r[19:12]});
                3'd5, 3'd6: storeInst(sf3, 5'd1, rs, {4'd0, r[19:12]});
                3'd7: placeWord({r[31:7], 7'b1110011});
                default: addiInst(rd, rs, r[31:20]);
            endcase
        end
        loadInst(3'b010, 5'd15, 5'd1, 12'd20);
        // all-zero words decode as no-ops
        for (int i = 0; i < 128; i++) begin
            placeWord(32'h0000_0000);
        end
        for (int i = 0; i < PauseLen; i++) begin
            r = $random(seed);
            pausePat[i] = {r[4:2] == 3'b000, r[1:0] == 2'b00};
        end
    endtask

    task automatic waitWriteBack(input int n);
        int cycles;
        cycles = 0;
        while (wbIdx <= n && cycles < WaitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (wbIdx <= n) begin
            timeoutErrors++;
            $display("timed out waiting for write-back %0d of %0d", n + 1, wbTotal);
        end
    endtask

    task automatic waitWrites();
        int cycles;
        cycles = 0;
        while (wrIdx < wrTotal && cycles < WaitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (wrIdx < wrTotal) begin
            timeoutErrors++;
            $display("timed out with %0d of %0d memory writes seen", wrIdx, wrTotal);
        end
    endtask

    initial begin
        for (int i = 0; i < 32; i++) begin
            regModel[i] = '0;
        end
        @(negedge clk);
        buildProgram();
        repeat (9) @(negedge clk);
        rst = 1'b0;
        pauseOn = 1'b1;
        for (int i = 0; i < wbTotal && timeoutErrors == 0; i++) begin
            waitWriteBack(i);
        end
        if (timeoutErrors == 0) begin
            waitWrites();
        end
        // quiet period over the no-op tail
        repeat (60) @(negedge clk);
        $display("errors: %0d value, %0d other, %0d timeout",
            valueErrors, otherErrors, timeoutErrors);
        if (valueErrors + otherErrors + timeoutErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: loadStoreCore.f
rtl/memPkg.sv
rtl/instPkg.sv
rtl/memCtrl.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/executeUnit.sv
rtl/resultUnit.sv
rtl/loadStoreCore.sv
dv/ramModel.sv
dv/loadStoreCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f loadStoreCore.f \
    --top-module loadStoreCoreTb \
    -Mdir obj_dir \
    -o loadStoreCoreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/loadStoreCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
